/* logic/aud_cfg.svh */
`ifndef AUD_CFG_SVH
`define AUD_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Sample and SRAM geometry
//////////////////////////////////////////////////////////////////////

`define AUD_SAMPLE_W        16          // Bits per left-channel sample
`define AUD_ADDR_W          20          // SRAM word address width

// Recording stops by itself once this many samples are stored
`define AUD_LIMIT_DEFAULT   20'd1024000

`define AUD_BUF_DEPTH       4           // Entries in the SRAM write buffer

//////////////////////////////////////////////////////////////////////
// AXI4-Lite register map, byte offsets
//////////////////////////////////////////////////////////////////////

`define AUD_REG_CMD         32'h0000_0000   // Write only, command code in [1:0]
`define AUD_REG_LIMIT       32'h0000_0004   // Read/write, sample limit
`define AUD_REG_STATUS      32'h0000_0008   // Read only, recorder status

`define AUD_RESP_OKAY       2'b00
`define AUD_RESP_SLVERR     2'b10

`endif

/* logic/aud_pkg.sv */
`include "aud_cfg.svh"

package aud_pkg;

//////////////////////////////////////////////////////////////////////
// Recorder state and command codes
//////////////////////////////////////////////////////////////////////

typedef enum logic [2:0] {
    REC_IDLE    = 3'd0,
    REC_WAIT    = 3'd1,     // Waiting for the left half of a frame
    REC_CAPTURE = 3'd2,
    REC_PAUSE   = 3'd3,     // Frames are skipped
    REC_FINISH  = 3'd4
} rec_state_e;

typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_START = 2'd1,
    CMD_PAUSE = 2'd2,       // Also resumes from pause
    CMD_STOP  = 2'd3
} rec_cmd_e;

//////////////////////////////////////////////////////////////////////
// Sample path and status
//////////////////////////////////////////////////////////////////////

typedef struct packed {
    logic                     valid;
    logic [`AUD_ADDR_W-1:0]   addr;
    logic [`AUD_SAMPLE_W-1:0] data;
} aud_sample_t;

typedef struct packed {
    rec_state_e             state;
    logic [`AUD_ADDR_W-1:0] count;      // Samples stored since start
    logic                   overrun;    // Sticky until the next start
} rec_status_t;

endpackage

/* logic/aud_ctrl_regs.sv */
`timescale 1ns/10ps
`include "aud_cfg.svh"

module aud_ctrl_regs (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // AXI4-Lite write
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  logic [31:0]            i_awaddr,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    input  logic [31:0]            i_wdata,
    output logic                   o_bvalid,
    input  logic                   i_bready,
    output logic [1:0]             o_bresp,
    // AXI4-Lite read
    input  logic                   i_arvalid,
    output logic                   o_arready,
    input  logic [31:0]            i_araddr,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output logic [31:0]            o_rdata,
    output logic [1:0]             o_rresp,
    // Recorder side
    input  aud_pkg::rec_status_t   i_status,
    output aud_pkg::rec_cmd_e      o_cmd,
    output logic [`AUD_ADDR_W-1:0] o_limit
);

logic                   wr_fire;
logic                   rd_fire;
logic                   wr_is_cmd;
logic                   wr_is_limit;
logic                   rd_hit;
logic [31:0]            rd_value;
logic                   bvalid_r;
logic [1:0]             bresp_r;
logic                   rvalid_r;
logic [1:0]             rresp_r;
logic [31:0]            rdata_r;
logic [`AUD_ADDR_W-1:0] limit_r;
aud_pkg::rec_cmd_e      cmd_stage_r;
aud_pkg::rec_cmd_e      cmd_r;

// Address and data are taken together, one write outstanding
assign wr_fire   = i_awvalid && i_wvalid && !bvalid_r;
assign o_awready = wr_fire;
assign o_wready  = wr_fire;
assign o_bvalid  = bvalid_r;
assign o_bresp   = bresp_r;

assign o_arready = !rvalid_r;
assign rd_fire   = i_arvalid && !rvalid_r;
assign o_rvalid  = rvalid_r;
assign o_rresp   = rresp_r;
assign o_rdata   = rdata_r;

assign o_cmd   = cmd_r;
assign o_limit = limit_r;

assign wr_is_cmd   = (i_awaddr == `AUD_REG_CMD);
assign wr_is_limit = (i_awaddr == `AUD_REG_LIMIT);

//////////////////////////////////////////////////////////////////////
// Read decode
//////////////////////////////////////////////////////////////////////

always_comb begin
    rd_value = '0;
    rd_hit   = 1'b1;
    case (i_araddr)
        `AUD_REG_CMD:    rd_value = '0;                         // Write only
        `AUD_REG_LIMIT:  rd_value[`AUD_ADDR_W-1:0] = limit_r;
        `AUD_REG_STATUS: rd_value[$bits(aud_pkg::rec_status_t)-1:0] = i_status;
        default:         rd_hit = 1'b0;
    endcase
end

//////////////////////////////////////////////////////////////////////
// Channel and register state
//////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        bvalid_r    <= 1'b0;
        bresp_r     <= `AUD_RESP_OKAY;
        rvalid_r    <= 1'b0;
        rresp_r     <= `AUD_RESP_OKAY;
        limit_r     <= `AUD_LIMIT_DEFAULT;
        cmd_stage_r <= aud_pkg::CMD_NONE;
        cmd_r       <= aud_pkg::CMD_NONE;
    end
    else begin
        if (wr_fire) begin
            bvalid_r <= 1'b1;
            bresp_r  <= (wr_is_cmd || wr_is_limit) ? `AUD_RESP_OKAY : `AUD_RESP_SLVERR;
        end
        else if (i_bready) begin
            bvalid_r <= 1'b0;
        end
        if (wr_fire && wr_is_limit) begin
            limit_r <= i_wdata[`AUD_ADDR_W-1:0];
        end
        // Pulse lands one cycle after bvalid rises
        cmd_stage_r <= (wr_fire && wr_is_cmd) ? aud_pkg::rec_cmd_e'(i_wdata[1:0])
                                              : aud_pkg::CMD_NONE;
        cmd_r       <= cmd_stage_r;
        if (rd_fire) begin
            rvalid_r <= 1'b1;
            rresp_r  <= rd_hit ? `AUD_RESP_OKAY : `AUD_RESP_SLVERR;
        end
        else if (i_rready) begin
            rvalid_r <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (rd_fire) begin
        rdata_r <= rd_value;
    end
end

endmodule

/* logic/aud_recorder.sv */
`timescale 1ns/10ps
`include "aud_cfg.svh"

module aud_recorder (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_lrc,
    input  logic                   i_data,
    input  aud_pkg::rec_cmd_e      i_cmd,
    input  logic [`AUD_ADDR_W-1:0] i_limit,
    output aud_pkg::aud_sample_t   o_sample,
    output aud_pkg::rec_state_e    o_state,
    output logic [`AUD_ADDR_W-1:0] o_count
);

localparam int BIT_W = $clog2(`AUD_SAMPLE_W);

aud_pkg::rec_state_e      state_r, state_w;
aud_pkg::aud_sample_t     sample_r, sample_w;
logic [`AUD_ADDR_W-1:0]   address_r, address_w;
logic [`AUD_ADDR_W-1:0]   address_inc;
logic [`AUD_SAMPLE_W-1:0] shift_r, shift_w;
logic [BIT_W-1:0]         counter_r, counter_w;
logic                     lrc_r;
logic                     pend_pause_r, pend_pause_w;
logic                     pend_stop_r, pend_stop_w;
logic                     lrc_fall;
logic                     cmd_open;
logic                     last_bit;

assign o_sample = sample_r;
assign o_state  = state_r;
assign o_count  = address_r;          // Address doubles as stored count

assign lrc_fall    = lrc_r && !i_lrc;     // First MSB edge of the left half
assign cmd_open    = (state_r == aud_pkg::REC_WAIT) || (state_r == aud_pkg::REC_PAUSE) || i_lrc;
assign last_bit    = (counter_r == BIT_W'(`AUD_SAMPLE_W - 1));
assign address_inc = address_r + 1'b1;

//////////////////////////////////////////////////////////////////////
// Next-state logic
//////////////////////////////////////////////////////////////////////

always_comb begin
    state_w        = state_r;
    address_w      = address_r;
    shift_w        = shift_r;
    counter_w      = counter_r;
    pend_pause_w   = pend_pause_r;
    pend_stop_w    = pend_stop_r;
    sample_w       = sample_r;
    sample_w.valid = 1'b0;

    // Pause and stop are held until the next frame boundary
    if (cmd_open) begin
        if (i_cmd == aud_pkg::CMD_PAUSE) begin
            pend_pause_w = 1'b1;
        end
        if (i_cmd == aud_pkg::CMD_STOP) begin
            pend_stop_w = 1'b1;
        end
    end

    case (state_r)
        aud_pkg::REC_IDLE: begin
            pend_pause_w = 1'b0;
            pend_stop_w  = 1'b0;
            if (i_cmd == aud_pkg::CMD_START) begin
                address_w = '0;
                state_w   = aud_pkg::REC_WAIT;
            end
        end
        aud_pkg::REC_WAIT: begin
            if (lrc_fall) begin
                if (pend_stop_w) begin
                    state_w = aud_pkg::REC_FINISH;
                end
                else if (pend_pause_w) begin
                    pend_pause_w = 1'b0;
                    state_w      = aud_pkg::REC_PAUSE;
                end
                else begin
                    shift_w   = {shift_r[`AUD_SAMPLE_W-2:0], i_data};   // MSB
                    counter_w = BIT_W'(1);
                    state_w   = aud_pkg::REC_CAPTURE;
                end
            end
        end
        aud_pkg::REC_CAPTURE: begin
            if (i_lrc) begin
                counter_w = '0;                       // Short frame, drop partial word
                state_w   = aud_pkg::REC_WAIT;
            end
            else if (last_bit) begin
                sample_w.valid = 1'b1;
                sample_w.addr  = address_r;
                sample_w.data  = {shift_r[`AUD_SAMPLE_W-2:0], i_data};
                address_w      = address_inc;
                counter_w      = '0;
                state_w        = (address_inc >= i_limit) ? aud_pkg::REC_FINISH
                                                          : aud_pkg::REC_WAIT;
            end
            else begin
                shift_w   = {shift_r[`AUD_SAMPLE_W-2:0], i_data};
                counter_w = counter_r + 1'b1;
            end
        end
        aud_pkg::REC_PAUSE: begin
            if (lrc_fall) begin
                if (pend_stop_w) begin
                    state_w = aud_pkg::REC_FINISH;
                end
                else if (pend_pause_w) begin
                    // Resume straight into this frame at the next address
                    pend_pause_w = 1'b0;
                    shift_w      = {shift_r[`AUD_SAMPLE_W-2:0], i_data};
                    counter_w    = BIT_W'(1);
                    state_w      = aud_pkg::REC_CAPTURE;
                end
            end
        end
        aud_pkg::REC_FINISH: begin
            pend_pause_w = 1'b0;
            pend_stop_w  = 1'b0;
            state_w      = aud_pkg::REC_IDLE;
        end
        default: begin
            state_w = aud_pkg::REC_IDLE;
        end
    endcase
end

//////////////////////////////////////////////////////////////////////
// Registers
//////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        state_r        <= aud_pkg::REC_IDLE;
        address_r      <= '0;
        counter_r      <= '0;
        lrc_r          <= 1'b0;
        pend_pause_r   <= 1'b0;
        pend_stop_r    <= 1'b0;
        sample_r.valid <= 1'b0;
    end
    else begin
        state_r        <= state_w;
        address_r      <= address_w;
        counter_r      <= counter_w;
        lrc_r          <= i_lrc;
        pend_pause_r   <= pend_pause_w;
        pend_stop_r    <= pend_stop_w;
        sample_r       <= sample_w;
    end
end

always_ff @(posedge i_clk) begin
    shift_r <= shift_w;
end

endmodule

/* logic/aud_sram_writer.sv */
`timescale 1ns/10ps
`include "aud_cfg.svh"

module aud_sram_writer (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  aud_pkg::aud_sample_t     i_sample,
    input  logic                     i_clear_overrun,
    input  logic                     i_sram_wait,
    output logic                     o_sram_we,
    output logic [`AUD_ADDR_W-1:0]   o_sram_addr,
    output logic [`AUD_SAMPLE_W-1:0] o_sram_data,
    output logic                     o_overrun
);

localparam int DEPTH = `AUD_BUF_DEPTH;
localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = PTR_W + 1;

logic [`AUD_ADDR_W-1:0]   buf_addr [DEPTH];
logic [`AUD_SAMPLE_W-1:0] buf_data [DEPTH];
logic [PTR_W-1:0]         wr_ptr_r, rd_ptr_r;
logic [CNT_W-1:0]         level_r;
logic                     overrun_r;
logic                     pop;
logic                     push;

// Oldest entry goes out whenever the SRAM is not stalling
assign pop  = (level_r != '0) && !i_sram_wait;
assign push = i_sample.valid && ((level_r != CNT_W'(DEPTH)) || pop);

assign o_sram_we   = pop;
assign o_sram_addr = buf_addr[rd_ptr_r];
assign o_sram_data = buf_data[rd_ptr_r];
assign o_overrun   = overrun_r;

//////////////////////////////////////////////////////////////////////
// Pointers, fill level and overrun flag
//////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        wr_ptr_r  <= '0;
        rd_ptr_r  <= '0;
        level_r   <= '0;
        overrun_r <= 1'b0;
    end
    else begin
        if (push) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;    // Depth is a power of two
        end
        if (pop) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
        end
        level_r <= level_r + CNT_W'(push) - CNT_W'(pop);
        if (i_clear_overrun) begin
            overrun_r <= 1'b0;
        end
        if (i_sample.valid && !push) begin
            overrun_r <= 1'b1;              // Sample lost on a full buffer
        end
    end
end

always_ff @(posedge i_clk) begin
    if (push) begin
        buf_addr[wr_ptr_r] <= i_sample.addr;
        buf_data[wr_ptr_r] <= i_sample.data;
    end
end

endmodule

/* logic/aud_rec_top.sv */
`timescale 1ns/10ps
`include "aud_cfg.svh"

module aud_rec_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_awvalid,
    output logic                     o_awready,
    input  logic [31:0]              i_awaddr,
    input  logic                     i_wvalid,
    output logic                     o_wready,
    input  logic [31:0]              i_wdata,
    output logic                     o_bvalid,
    input  logic                     i_bready,
    output logic [1:0]               o_bresp,
    input  logic                     i_arvalid,
    output logic                     o_arready,
    input  logic [31:0]              i_araddr,
    output logic                     o_rvalid,
    input  logic                     i_rready,
    output logic [31:0]              o_rdata,
    output logic [1:0]               o_rresp,
    input  logic                     i_lrc,
    input  logic                     i_data,
    input  logic                     i_sram_wait,
    output logic                     o_sram_we,
    output logic [`AUD_ADDR_W-1:0]   o_sram_addr,
    output logic [`AUD_SAMPLE_W-1:0] o_sram_data
);

aud_pkg::rec_cmd_e      cmd;
aud_pkg::rec_state_e    rec_state;
aud_pkg::rec_status_t   status;
aud_pkg::aud_sample_t   sample;
logic [`AUD_ADDR_W-1:0] limit;
logic [`AUD_ADDR_W-1:0] count;
logic                   overrun;

assign status.state   = rec_state;
assign status.count   = count;
assign status.overrun = overrun;

aud_ctrl_regs u_regs (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .i_status  (status),
    .o_cmd     (cmd),
    .o_limit   (limit)
);

aud_recorder u_recorder (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_lrc    (i_lrc),
    .i_data   (i_data),
    .i_cmd    (cmd),
    .i_limit  (limit),
    .o_sample (sample),
    .o_state  (rec_state),
    .o_count  (count)
);

aud_sram_writer u_writer (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_sample        (sample),
    .i_clear_overrun (cmd == aud_pkg::CMD_START),     // New recording clears overrun
    .i_sram_wait     (i_sram_wait),
    .o_sram_we       (o_sram_we),
    .o_sram_addr     (o_sram_addr),
    .o_sram_data     (o_sram_data),
    .o_overrun       (overrun)
);

endmodule

/* tb/aud_rec_checker.sv */
`timescale 1ns/10ps
`include "aud_cfg.svh"

module aud_rec_checker (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_lrc,
    input  logic                     i_data,
    input  logic                     i_rec,
    input  logic                     i_sram_we,
    input  logic [`AUD_ADDR_W-1:0]   i_sram_addr,
    input  logic [`AUD_SAMPLE_W-1:0] i_sram_data,
    output int                       o_failed
);

logic [`AUD_ADDR_W+`AUD_SAMPLE_W-1:0] exp_q [$];     // {address, data}
logic [`AUD_ADDR_W+`AUD_SAMPLE_W-1:0] exp_entry;
logic [`AUD_ADDR_W-1:0]               exp_addr;
logic [`AUD_SAMPLE_W-1:0]             arrival;        // Bit 0 is the first one received
logic                                 lrc_q;
logic                                 collecting;
int                                   bit_idx;
string                                test_name;
int                                   test_errors;
int                                   test_writes;
int                                   passed;

initial begin
    o_failed  = 0;
    passed    = 0;
    test_name = "none";
    exp_addr  = '0;
end

// Left word from the serial bits, MSB first on the wire
function automatic logic [`AUD_SAMPLE_W-1:0] aud_expected_word(
        input logic [`AUD_SAMPLE_W-1:0] serial);
    logic [`AUD_SAMPLE_W-1:0] word;
    word = '0;
    for (int i = 0; i < `AUD_SAMPLE_W; i++) begin
        word = {word[`AUD_SAMPLE_W-2:0], serial[i]};
    end
    return word;
endfunction

//////////////////////////////////////////////////////////////////////
// Frame capture and SRAM write comparison
//////////////////////////////////////////////////////////////////////

always @(posedge i_clk) begin
    if (i_rst_n) begin
        lrc_q      <= 1'b1;
        collecting <= 1'b0;
        bit_idx    <= 0;
    end
    else begin
        lrc_q <= i_lrc;
        if (lrc_q && !i_lrc) begin
            arrival[0] = i_data;
            bit_idx    <= 1;
            collecting <= 1'b1;
        end
        else if (collecting && !i_lrc) begin
            arrival[bit_idx] = i_data;
            if (bit_idx == `AUD_SAMPLE_W - 1) begin
                collecting <= 1'b0;
                if (i_rec) begin
                    exp_q.push_back({exp_addr, aud_expected_word(arrival)});
                    exp_addr = exp_addr + 1'b1;
                end
            end
            else begin
                bit_idx <= bit_idx + 1;
            end
        end
        if (i_sram_we) begin
            test_writes++;
            if (exp_q.size() == 0) begin
                $display("Test %s: SRAM write to address %h when no write was expected",
                         test_name, i_sram_addr);
                test_errors++;
            end
            else begin
                exp_entry = exp_q.pop_front();
                if (exp_entry[`AUD_ADDR_W+`AUD_SAMPLE_W-1:`AUD_SAMPLE_W] !== i_sram_addr) begin
                    $display("Mismatch in test %s: SRAM address expected %h, actual %h", test_name,
                             exp_entry[`AUD_ADDR_W+`AUD_SAMPLE_W-1:`AUD_SAMPLE_W], i_sram_addr);
                    test_errors++;
                end
                if (exp_entry[`AUD_SAMPLE_W-1:0] !== i_sram_data) begin
                    $display("Mismatch in test %s: SRAM data expected %h, actual %h", test_name,
                             exp_entry[`AUD_SAMPLE_W-1:0], i_sram_data);
                    test_errors++;
                end
            end
        end
    end
end

//////////////////////////////////////////////////////////////////////
// Test bookkeeping
//////////////////////////////////////////////////////////////////////

task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_writes = 0;
    exp_addr    = '0;                 // A start always records from address 0
    exp_q.delete();
endtask

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("Mismatch in test %s, %s: expected %h, actual %h",
                 test_name, what, expected, actual);
        test_errors++;
    end
endtask

task automatic end_test();
    if (exp_q.size() != 0) begin
        $display("Test %s ended with %0d expected SRAM writes that never arrived",
                 test_name, exp_q.size());
        test_errors++;
        exp_q.delete();
    end
    if (test_errors == 0) begin
        passed++;
        $display("Test %s passed, %0d SRAM writes checked", test_name, test_writes);
    end
    else begin
        o_failed++;
        $display("Test %s failed with %0d errors", test_name, test_errors);
    end
endtask

task automatic print_counts();
    $display("%0d tests passed, %0d tests failed", passed, o_failed);
endtask

endmodule

/* tb/tb_aud_rec.sv */
`timescale 1ns/10ps
`include "aud_cfg.svh"

module tb_aud_rec;

localparam int FRAMES_BASIC   = 10;
localparam int FRAMES_PAUSE   = 12;
localparam int FRAMES_LIMIT   = 8;
localparam int FRAMES_STALL   = 8;
localparam int FRAMES_RESTART = 5;
localparam int TOTAL_FRAMES   = FRAMES_BASIC + FRAMES_PAUSE + FRAMES_LIMIT
                                + FRAMES_STALL + FRAMES_RESTART;
localparam int WATCHDOG_NS    = TOTAL_FRAMES * 32 * 10 + 2000;

logic                     i_clk = 1'b0;
logic                     i_rst_n;
logic                     i_awvalid;
logic                     o_awready;
logic [31:0]              i_awaddr;
logic                     i_wvalid;
logic                     o_wready;
logic [31:0]              i_wdata;
logic                     o_bvalid;
logic                     i_bready;
logic [1:0]               o_bresp;
logic                     i_arvalid;
logic                     o_arready;
logic [31:0]              i_araddr;
logic                     o_rvalid;
logic                     i_rready;
logic [31:0]              o_rdata;
logic [1:0]               o_rresp;
logic                     i_lrc = 1'b1;
logic                     i_data = 1'b0;
logic                     i_sram_wait = 1'b0;
logic                     o_sram_we;
logic [`AUD_ADDR_W-1:0]   o_sram_addr;
logic [`AUD_SAMPLE_W-1:0] o_sram_data;

integer                   seed = 32'h5d34_6b27;
logic [31:0]              rand_word;
logic [`AUD_SAMPLE_W-1:0] cur_word;
int                       bit_pos = 16;       // Codec starts in the right half
int                       frame_count = 0;
logic                     rec_next = 1'b0;    // Announcement for the coming frame
logic                     rec_frame = 1'b0;
int                       stall_left = 0;
int                       fail_count;
logic [31:0]              rd_data;
logic [1:0]               resp;

always #5 i_clk = ~i_clk;

aud_rec_top i_dut (.*);

aud_rec_checker u_checker (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_lrc       (i_lrc),
    .i_data      (i_data),
    .i_rec       (rec_frame),
    .i_sram_we   (o_sram_we),
    .i_sram_addr (o_sram_addr),
    .i_sram_data (o_sram_data),
    .o_failed    (fail_count)
);

//////////////////////////////////////////////////////////////////////
// Codec model and SRAM stall generator
//////////////////////////////////////////////////////////////////////

always @(posedge i_clk) begin
    if (i_rst_n) begin
        i_lrc   <= 1'b1;
        i_data  <= 1'b0;
        bit_pos <= 16;
    end
    else begin
        if (bit_pos == 0) begin
            rand_word = $random(seed);
            cur_word    <= rand_word[`AUD_SAMPLE_W-1:0];
            i_lrc       <= 1'b0;
            i_data      <= rand_word[`AUD_SAMPLE_W-1];      // MSB with the falling lrc
            rec_frame   <= rec_next;
            frame_count <= frame_count + 1;
        end
        else if (bit_pos < 16) begin
            i_data <= cur_word[15 - bit_pos];
        end
        else begin
            i_lrc  <= 1'b1;                                 // Right half carries nothing
            i_data <= 1'b0;
        end
        bit_pos <= (bit_pos + 1) % 32;
    end
end

always @(posedge i_clk) begin
    if (stall_left > 0) begin
        i_sram_wait <= 1'b1;
        stall_left  <= stall_left - 1;
    end
    else begin
        i_sram_wait <= 1'b0;
    end
end

//////////////////////////////////////////////////////////////////////
// Bus and frame helpers
//////////////////////////////////////////////////////////////////////

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                         output logic [1:0] bresp);
    @(posedge i_clk);
    i_awvalid <= 1'b1;
    i_awaddr  <= addr;
    i_wvalid  <= 1'b1;
    i_wdata   <= data;
    i_bready  <= 1'b1;
    do @(posedge i_clk); while (!(o_awready && o_wready));
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    do @(posedge i_clk); while (!o_bvalid);
    bresp = o_bresp;
    i_bready <= 1'b0;
endtask

task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                        output logic [1:0] rresp);
    @(posedge i_clk);
    i_arvalid <= 1'b1;
    i_araddr  <= addr;
    i_rready  <= 1'b1;
    do @(posedge i_clk); while (!o_arready);
    i_arvalid <= 1'b0;
    do @(posedge i_clk); while (!o_rvalid);
    data  = o_rdata;
    rresp = o_rresp;
    i_rready <= 1'b0;
endtask

// Waits for the right half, announces the next frame, then sends the command
task automatic next_frame(input aud_pkg::rec_cmd_e cmd, input logic rec);
    logic [1:0] bresp;
    @(posedge i_lrc);
    rec_next = rec;
    if (cmd != aud_pkg::CMD_NONE) begin
        write_reg(`AUD_REG_CMD, {30'd0, cmd}, bresp);
        u_checker.check_value("CMD write response", `AUD_RESP_OKAY, bresp);
    end
endtask

task automatic run_frames(input int n, input logic rec);
    repeat (n) next_frame(aud_pkg::CMD_NONE, rec);
endtask

function automatic logic [31:0] status_word(input aud_pkg::rec_state_e state,
                                            input logic [`AUD_ADDR_W-1:0] count,
                                            input logic overrun);
    status_word = {8'd0, state, count, overrun};
endfunction

task automatic check_status(input logic [`AUD_ADDR_W-1:0] count, input logic overrun);
    logic [31:0] data;
    logic [1:0]  rresp;
    read_reg(`AUD_REG_STATUS, data, rresp);
    u_checker.check_value("STATUS", status_word(aud_pkg::REC_IDLE, count, overrun), data);
    u_checker.check_value("STATUS read response", `AUD_RESP_OKAY, rresp);
endtask

//////////////////////////////////////////////////////////////////////
// Test sequence and watchdog
//////////////////////////////////////////////////////////////////////

initial begin
    i_rst_n   = 1'b1;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_araddr  = '0;
    i_rready  = 1'b0;
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b0;

    u_checker.begin_test("basic_record");
    next_frame(aud_pkg::CMD_START, 1'b1);
    run_frames(7, 1'b1);
    next_frame(aud_pkg::CMD_STOP, 1'b0);
    run_frames(1, 1'b0);
    check_status(20'd8, 1'b0);
    u_checker.end_test();

    u_checker.begin_test("pause_resume");
    next_frame(aud_pkg::CMD_START, 1'b1);
    run_frames(2, 1'b1);
    next_frame(aud_pkg::CMD_PAUSE, 1'b0);
    run_frames(3, 1'b0);                            // Four frames skipped in total
    next_frame(aud_pkg::CMD_PAUSE, 1'b1);
    run_frames(2, 1'b1);
    next_frame(aud_pkg::CMD_STOP, 1'b0);
    run_frames(1, 1'b0);
    check_status(20'd6, 1'b0);
    u_checker.end_test();

    u_checker.begin_test("limit");
    write_reg(`AUD_REG_LIMIT, 32'd5, resp);
    u_checker.check_value("LIMIT write response", `AUD_RESP_OKAY, resp);
    next_frame(aud_pkg::CMD_START, 1'b1);
    run_frames(4, 1'b1);
    run_frames(3, 1'b0);
    check_status(20'd5, 1'b0);
    u_checker.end_test();

    u_checker.begin_test("back_pressure");
    write_reg(`AUD_REG_LIMIT, 32'd1000, resp);
    next_frame(aud_pkg::CMD_START, 1'b1);
    next_frame(aud_pkg::CMD_NONE, 1'b1);
    repeat (28) @(posedge i_clk);
    stall_left <= 40;                               // Spans two sample arrivals
    run_frames(4, 1'b1);
    next_frame(aud_pkg::CMD_STOP, 1'b0);
    run_frames(1, 1'b0);
    check_status(20'd6, 1'b0);
    u_checker.end_test();

    u_checker.begin_test("registers_restart");
    write_reg(`AUD_REG_LIMIT, 32'h0000_abcd, resp);
    u_checker.check_value("LIMIT write response", `AUD_RESP_OKAY, resp);
    read_reg(`AUD_REG_LIMIT, rd_data, resp);
    u_checker.check_value("LIMIT readback", 32'h0000_abcd, rd_data);
    u_checker.check_value("LIMIT read response", `AUD_RESP_OKAY, resp);
    read_reg(32'h0000_000c, rd_data, resp);
    u_checker.check_value("unmapped read data", 32'd0, rd_data);
    u_checker.check_value("unmapped read response", `AUD_RESP_SLVERR, resp);
    next_frame(aud_pkg::CMD_START, 1'b1);
    run_frames(2, 1'b1);
    next_frame(aud_pkg::CMD_STOP, 1'b0);
    run_frames(1, 1'b0);
    check_status(20'd3, 1'b0);
    u_checker.end_test();

    u_checker.print_counts();
    if (fail_count == 0) begin
        $display("TEST OK");
    end
    else begin
        $display("TEST FAILED");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, %0d codec frames sent", WATCHDOG_NS, frame_count);
    $display("TEST FAILED");
    $finish;
end

endmodule

/* src.f */
+incdir+logic
logic/aud_pkg.sv
logic/aud_ctrl_regs.sv
logic/aud_recorder.sv
logic/aud_sram_writer.sv
logic/aud_rec_top.sv
tb/aud_rec_checker.sv
tb/tb_aud_rec.sv

/* Bender.yml */
package:
  name: aud_rec

sources:
  - include_dirs:
      - logic
    files:
      - logic/aud_pkg.sv
      - logic/aud_ctrl_regs.sv
      - logic/aud_recorder.sv
      - logic/aud_sram_writer.sv
      - logic/aud_rec_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/aud_rec_checker.sv
      - tb/tb_aud_rec.sv
